// ==== run_sim.sh ====
#!/bin/sh
# Build the scalar unit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f src.f --top-module tb_scalar_unit -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ/Vtb_scalar_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

// ==== src.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_if.sv
src/program_counter.sv
src/instr_mem.sv
src/hazard_check.sv
src/reg_file.sv
src/exec_unit.sv
src/scalar_unit.sv
tb/tb_scalar_unit.sv

// ==== src/exec_unit.sv ====
// Two-stage execution: ALU and compare, branch resolution, registered write-back
`default_nettype none

module exec_unit #(
	parameter int DATA_W = pipe_pkg::DATA_W
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            run,
	operand_if.receiver     operand,
	wb_if.source            wb,
	output logic            resolve,
	output logic            redirect,
	output pipe_pkg::addr_t target,
	output logic            cond_pending_clear,
	output logic            term
);

	localparam int SHAMT_W = $clog2(DATA_W);

	isa_pkg::opcode_e   op;
	logic [DATA_W-1:0]  a;
	logic [DATA_W-1:0]  b;
	logic [DATA_W-1:0]  imm_ext;
	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0]  alu_res;
	logic               less;
	logic               s1_valid;
	isa_pkg::opcode_e   s1_op;
	pipe_pkg::reg_idx_t s1_dst;
	logic [DATA_W-1:0]  s1_res;
	pipe_pkg::addr_t    s1_target;
	logic               s1_ctrl;
	logic               cond_q;
	logic               term_q;
	logic               wb_valid_q;
	pipe_pkg::reg_idx_t wb_dst_q;
	logic [DATA_W-1:0]  wb_data_q;

	//////////////////////////////
	// Stage one
	assign op      = operand.instr.reg_form.opcode;
	assign a       = operand.op1;
	assign b       = operand.op2;
	assign imm_ext = DATA_W'(signed'(operand.instr.imm_form.imm));
	assign shamt   = b[SHAMT_W-1:0];
	assign less    = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			isa_pkg::OP_ADD:  alu_res = a + b;
			isa_pkg::OP_SUB:  alu_res = a - b;
			isa_pkg::OP_AND:  alu_res = a & b;
			isa_pkg::OP_OR:   alu_res = a | b;
			isa_pkg::OP_XOR:  alu_res = a ^ b;
			isa_pkg::OP_SHL:  alu_res = a << shamt;
			isa_pkg::OP_SHR:  alu_res = a >> shamt;
			isa_pkg::OP_ADDI: alu_res = a + imm_ext;
			default:          alu_res = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid   <= 1'b0;
			cond_q     <= 1'b0;
			wb_valid_q <= 1'b0;
			term_q     <= 1'b0;
		end else if (run) begin
			s1_valid <= operand.valid;
			if (operand.valid && op == isa_pkg::OP_CMPLT) begin
				cond_q <= less;
			end
			wb_valid_q <= s1_valid & isa_pkg::writes_reg(s1_op);
			// Halt at the end of execute stays until reset
			if (s1_valid && s1_op == isa_pkg::OP_HALT) begin
				term_q <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Stage two payload
	always_ff @(posedge clock) begin
		if (run) begin
			s1_op     <= op;
			s1_dst    <= operand.instr.reg_form.dst;
			s1_res    <= alu_res;
			s1_target <= pipe_pkg::addr_t'(operand.instr.imm_form.imm);
			wb_dst_q  <= s1_dst;
			wb_data_q <= s1_res;
		end
	end

	// Branch outcome as the control op leaves stage one
	assign s1_ctrl            = run & s1_valid & isa_pkg::is_control(s1_op);
	assign resolve            = s1_ctrl;
	assign redirect           = s1_ctrl & ((s1_op == isa_pkg::OP_JMP) | cond_q);
	assign target             = s1_target;
	assign cond_pending_clear = run & s1_valid & (s1_op == isa_pkg::OP_CMPLT);
	assign term               = term_q;

	assign wb.valid = run & wb_valid_q;
	assign wb.dst   = wb_dst_q;
	assign wb.data  = wb_data_q;

	a_ctrl_no_writeback: assert property (@(posedge clock) disable iff (reset)
		resolve |=> !wb_valid_q && !s1_valid)
		else $error("control op followed by a write-back or a younger op");

endmodule

`default_nettype wire

// ==== src/hazard_check.sv ====
// Decode and scoreboard: issues one instruction per cycle or stalls fetch
`default_nettype none

module hazard_check (
	input  logic            clock,
	input  logic            reset,
	input  logic            run,
	input  isa_pkg::instr_u fetch_instr,
	input  logic            fetch_valid,
	input  logic            resolve,
	wb_if.receiver          wb,
	input  logic            cond_pending_clear,
	output logic            hold,
	output logic            issue_valid,
	output isa_pkg::instr_u issue_instr
);

	localparam int NUM_REGS = 2 ** isa_pkg::REG_IDX_W;

	isa_pkg::opcode_e    op;
	pipe_pkg::reg_idx_t  dst;
	pipe_pkg::reg_idx_t  src1;
	pipe_pkg::reg_idx_t  src2;
	logic [NUM_REGS-1:0] reg_pending;
	logic                cond_pending;
	logic                wait_ctrl;
	logic                halt_seen;
	logic                writes;
	logic                reads1;
	logic                reads2;
	logic                is_cmplt;
	logic                is_bc;
	logic                raw_stall;
	logic                cond_stall;

	//////////////////////////////
	// Decode
	assign op       = fetch_instr.reg_form.opcode;
	assign dst      = fetch_instr.reg_form.dst;
	assign src1     = fetch_instr.reg_form.src1;
	assign src2     = fetch_instr.reg_form.src2;
	assign is_cmplt = (op == isa_pkg::OP_CMPLT);
	assign is_bc    = (op == isa_pkg::OP_BC);
	assign writes   = isa_pkg::writes_reg(op);
	assign reads1   = writes | is_cmplt;
	assign reads2   = (writes & (op != isa_pkg::OP_ADDI)) | is_cmplt;

	//////////////////////////////
	// Stall and issue
	// Sources and dst wait for write-back so write-backs stay ordered
	assign raw_stall  = (reads1 & reg_pending[src1]) | (reads2 & reg_pending[src2]) |
		(writes & reg_pending[dst]);
	assign cond_stall = (is_bc | is_cmplt) & cond_pending;

	assign hold        = halt_seen | wait_ctrl | (fetch_valid & (raw_stall | cond_stall));
	assign issue_valid = run & fetch_valid & ~hold;
	assign issue_instr = fetch_instr;

	// Scoreboard bits, never set for r0
	always_ff @(posedge clock) begin
		if (reset) begin
			reg_pending  <= '0;
			cond_pending <= 1'b0;
			wait_ctrl    <= 1'b0;
			halt_seen    <= 1'b0;
		end else begin
			if (wb.valid) begin
				reg_pending[wb.dst] <= 1'b0;
			end
			if (issue_valid && writes && dst != '0) begin
				reg_pending[dst] <= 1'b1;
			end
			if (cond_pending_clear) begin
				cond_pending <= 1'b0;
			end
			if (issue_valid && is_cmplt) begin
				cond_pending <= 1'b1;
			end
			// Word fetched behind the branch is dropped by staying in wait until resolve
			if (resolve) begin
				wait_ctrl <= 1'b0;
			end
			if (issue_valid && isa_pkg::is_control(op)) begin
				wait_ctrl <= 1'b1;
			end
			if (issue_valid && op == isa_pkg::OP_HALT) begin
				halt_seen <= 1'b1;
			end
		end
	end

	a_no_pending_source: assert property (@(posedge clock) disable iff (reset)
		issue_valid && wb.valid |->
			!(reads1 && src1 != '0 && src1 == wb.dst) &&
			!(reads2 && src2 != '0 && src2 == wb.dst))
		else $error("issued with a source still in write-back");

endmodule

`default_nettype wire

// ==== src/instr_mem.sv ====
// Instruction memory with a store handshake for loading and a registered fetch port
`default_nettype none

module instr_mem #(
	parameter int PROG_DEPTH = 256
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            store_req,
	input  isa_pkg::instr_u store_instr,
	output logic            store_ack,
	input  logic            run,
	input  pipe_pkg::addr_t pc,
	output isa_pkg::instr_u fetch_instr,
	output logic            fetch_valid
);

	isa_pkg::instr_u mem [PROG_DEPTH];
	pipe_pkg::addr_t wr_addr;
	logic            ack_q;
	logic            rd_valid_q;
	logic            store_take;

	// A request is taken once, the ack cycle blocks a second write
	assign store_take = store_req & ~ack_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q      <= 1'b0;
			wr_addr    <= '0;
			rd_valid_q <= 1'b0;
		end else begin
			ack_q <= store_take;
			if (store_take) begin
				wr_addr <= wr_addr + pipe_pkg::addr_t'(1);
			end
			if (run) begin
				rd_valid_q <= 1'b1;
			end
		end
	end

	// Array write and registered read
	always_ff @(posedge clock) begin
		if (store_take) begin
			mem[wr_addr] <= store_instr;
		end
		if (run) begin
			fetch_instr <= mem[pc];
		end
	end

	assign store_ack   = ack_q;
	assign fetch_valid = rd_valid_q & run;

endmodule

`default_nettype wire

// ==== src/isa_pkg.sv ====
// Instruction set of the scalar unit: opcodes, field widths and the instruction word
`default_nettype none

package isa_pkg;

	localparam int REG_IDX_W = 5;
	localparam int IMM_W     = 16;

	typedef enum logic [5:0] {
		OP_NOP   = 6'h00,
		OP_ADD   = 6'h01,
		OP_SUB   = 6'h02,
		OP_AND   = 6'h03,
		OP_OR    = 6'h04,
		OP_XOR   = 6'h05,
		OP_SHL   = 6'h06,
		OP_SHR   = 6'h07,
		OP_ADDI  = 6'h08,
		OP_CMPLT = 6'h09,
		OP_JMP   = 6'h0a,
		OP_BC    = 6'h0b,
		OP_HALT  = 6'h0c
	} opcode_e;

	// Three-register form
	typedef struct packed {
		opcode_e                opcode;
		logic [REG_IDX_W-1:0]   dst;
		logic [REG_IDX_W-1:0]   src1;
		logic [REG_IDX_W-1:0]   src2;
		logic [10:0]            tail;
	} reg_form_t;

	// Immediate form, imm is the target address for jmp and bc
	typedef struct packed {
		opcode_e                opcode;
		logic [REG_IDX_W-1:0]   dst;
		logic [REG_IDX_W-1:0]   src1;
		logic [IMM_W-1:0]       imm;
	} imm_form_t;

	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} instr_u;

	// Ops that produce a register write-back
	function automatic logic writes_reg(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_ADDI};
	endfunction

	function automatic logic is_control(opcode_e op);
		return op inside {OP_JMP, OP_BC};
	endfunction

endpackage

`default_nettype wire

// ==== src/pipe_if.sv ====
// Operand and write-back buses between register file and execution unit
`default_nettype none

// Read operands with their instruction, register file to execute
interface operand_if #(
	parameter int DATA_W = $bits(pipe_pkg::data_t)
);
	logic              valid;
	isa_pkg::instr_u   instr;
	logic [DATA_W-1:0] op1;
	logic [DATA_W-1:0] op2;

	modport source (output valid, instr, op1, op2);
	modport receiver (input valid, instr, op1, op2);
endinterface

// Result write-back, also clears the scoreboard
interface wb_if #(
	parameter int DATA_W = $bits(pipe_pkg::data_t)
);
	logic               valid;
	pipe_pkg::reg_idx_t dst;
	logic [DATA_W-1:0]  data;

	modport source (output valid, dst, data);
	modport receiver (input valid, dst, data);
endinterface

`default_nettype wire

// ==== src/pipe_pkg.sv ====
// Pipeline sizes of the scalar unit: data word, register index and program address
`default_nettype none

package pipe_pkg;

	// Data word
	localparam int DATA_W = 32;
	typedef logic [DATA_W-1:0] data_t;

	// Register index, low bit picks the bank (0 even, 1 odd)
	typedef logic [isa_pkg::REG_IDX_W-1:0] reg_idx_t;

	// Registers held in each of the two banks
	localparam int BANK_REGS = 2 ** (isa_pkg::REG_IDX_W - 1);

	// Program address
	localparam int PROG_ADDR_W = 8;
	typedef logic [PROG_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== src/program_counter.sv ====
// Program counter: sequential fetch, stall re-read, branch redirect and halt freeze
`default_nettype none

module program_counter (
	input  logic            clock,
	input  logic            reset,
	input  logic            run,
	input  logic            hold,
	input  logic            resolve,
	input  logic            redirect,
	input  pipe_pkg::addr_t target,
	input  logic            term,
	output pipe_pkg::addr_t pc
);

	pipe_pkg::addr_t next_q;
	pipe_pkg::addr_t fetch_addr_q;
	pipe_pkg::addr_t branch_addr_q;
	pipe_pkg::addr_t pc_sel;
	logic            advance;

	// Resolve wins, a stall re-reads the word sitting in fetch
	always_comb begin
		if (resolve) begin
			pc_sel = redirect ? target : branch_addr_q + pipe_pkg::addr_t'(1);
		end else if (hold) begin
			pc_sel = fetch_addr_q;
		end else begin
			pc_sel = next_q;
		end
	end

	assign advance = run & ~term;
	assign pc      = pc_sel;

	always_ff @(posedge clock) begin
		if (reset) begin
			next_q        <= '0;
			fetch_addr_q  <= '0;
			branch_addr_q <= '0;
		end else if (advance) begin
			fetch_addr_q <= pc_sel;
			if (resolve || !hold) begin
				next_q <= pc_sel + pipe_pkg::addr_t'(1);
			end
			// Last issued address, frozen while a branch waits
			if (!resolve && !hold) begin
				branch_addr_q <= fetch_addr_q;
			end
		end
	end

	a_pc_frozen_after_term: assert property (@(posedge clock) disable iff (reset)
		term |=> $stable(pc))
		else $error("pc moved after termination");

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Register file in odd and even banks, one-cycle operand read and write-back port
`default_nettype none

module reg_file #(
	parameter int DATA_W = pipe_pkg::DATA_W
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            run,
	input  logic            issue_valid,
	input  isa_pkg::instr_u issue_instr,
	wb_if.receiver          wb,
	operand_if.source       operand
);

	localparam int BANK_IDX_W = isa_pkg::REG_IDX_W - 1;

	logic [DATA_W-1:0] bank_even [pipe_pkg::BANK_REGS];
	logic [DATA_W-1:0] bank_odd  [pipe_pkg::BANK_REGS];
	logic              we_even;
	logic              we_odd;
	logic              op_valid_q;
	isa_pkg::instr_u   op_instr_q;
	logic [DATA_W-1:0] op1_q;
	logic [DATA_W-1:0] op2_q;

	// r0 reads as zero
	function automatic logic [DATA_W-1:0] read_reg(pipe_pkg::reg_idx_t idx);
		logic [DATA_W-1:0] val;
		if (idx == '0) begin
			val = '0;
		end else if (idx[0]) begin
			val = bank_odd[idx[BANK_IDX_W:1]];
		end else begin
			val = bank_even[idx[BANK_IDX_W:1]];
		end
		return val;
	endfunction

	assign we_even = wb.valid & ~wb.dst[0];
	assign we_odd  = wb.valid & wb.dst[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			op_valid_q <= 1'b0;
		end else if (run) begin
			op_valid_q <= issue_valid;
		end
	end

	// Operand capture and bank writes
	always_ff @(posedge clock) begin
		if (run) begin
			op_instr_q <= issue_instr;
			op1_q      <= read_reg(issue_instr.reg_form.src1);
			op2_q      <= read_reg(issue_instr.reg_form.src2);
		end
		if (we_even) begin
			bank_even[wb.dst[BANK_IDX_W:1]] <= wb.data;
		end
		if (we_odd) begin
			bank_odd[wb.dst[BANK_IDX_W:1]] <= wb.data;
		end
	end

	assign operand.valid = op_valid_q;
	assign operand.instr = op_instr_q;
	assign operand.op1   = op1_q;
	assign operand.op2   = op2_q;

	a_bank_write_running: assert property (@(posedge clock) disable iff (reset)
		(we_even || we_odd) |-> run)
		else $error("register bank written while run is low");

endmodule

`default_nettype wire

// ==== src/scalar_unit.sv ====
// Scalar unit top level: fetch, issue, register read, execute and write-back
`default_nettype none

module scalar_unit #(
	parameter int PROG_DEPTH = 256,
	parameter int DATA_W     = pipe_pkg::DATA_W
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               run,
	input  logic               store_req,
	input  isa_pkg::instr_u    store_instr,
	output logic               store_ack,
	output logic               wb_valid,
	output pipe_pkg::reg_idx_t wb_dst,
	output logic [DATA_W-1:0]  wb_data,
	output logic               term
);

	pipe_pkg::addr_t pc;
	pipe_pkg::addr_t target;
	isa_pkg::instr_u fetch_instr;
	isa_pkg::instr_u issue_instr;
	logic            fetch_valid;
	logic            issue_valid;
	logic            hold;
	logic            resolve;
	logic            redirect;
	logic            cond_pending_clear;

	operand_if #(.DATA_W(DATA_W)) operand_bus ();
	wb_if #(.DATA_W(DATA_W)) wb_bus ();

	//////////////////////////////
	// Front end
	program_counter u_pc (
		.clock    (clock),
		.reset    (reset),
		.run      (run),
		.hold     (hold),
		.resolve  (resolve),
		.redirect (redirect),
		.target   (target),
		.term     (term),
		.pc       (pc)
	);

	instr_mem #(
		.PROG_DEPTH (PROG_DEPTH)
	) u_imem (
		.clock       (clock),
		.reset       (reset),
		.store_req   (store_req),
		.store_instr (store_instr),
		.store_ack   (store_ack),
		.run         (run),
		.pc          (pc),
		.fetch_instr (fetch_instr),
		.fetch_valid (fetch_valid)
	);

	hazard_check u_hazard (
		.clock              (clock),
		.reset              (reset),
		.run                (run),
		.fetch_instr        (fetch_instr),
		.fetch_valid        (fetch_valid),
		.resolve            (resolve),
		.wb                 (wb_bus),
		.cond_pending_clear (cond_pending_clear),
		.hold               (hold),
		.issue_valid        (issue_valid),
		.issue_instr        (issue_instr)
	);

	//////////////////////////////
	// Back end
	reg_file #(
		.DATA_W (DATA_W)
	) u_rf (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.issue_valid (issue_valid),
		.issue_instr (issue_instr),
		.wb          (wb_bus),
		.operand     (operand_bus)
	);

	exec_unit #(
		.DATA_W (DATA_W)
	) u_exec (
		.clock              (clock),
		.reset              (reset),
		.run                (run),
		.operand            (operand_bus),
		.wb                 (wb_bus),
		.resolve            (resolve),
		.redirect           (redirect),
		.target             (target),
		.cond_pending_clear (cond_pending_clear),
		.term               (term)
	);

	assign wb_valid = wb_bus.valid;
	assign wb_dst   = wb_bus.dst;
	assign wb_data  = wb_bus.data;

endmodule

`default_nettype wire

// ==== tb/scalar_trace.txt ====
# Columns: P <instruction word, hex> | W <dst register, hex> <data, hex>
# T <write-backs before term, decimal>; W lines are in write-back order
P 20200005  # 00 addi r1, r0, 5
P 2040000c  # 01 addi r2, r0, 12
P 04611000  # 02 add r3, r1, r2
P 08830800  # 03 sub r4, r3, r1
P 0ca40800  # 04 and r5, r4, r1
P 10c51800  # 05 or r6, r5, r3
P 14e61000  # 06 xor r7, r6, r2
P 19070800  # 07 shl r8, r7, r1
P 21400003  # 08 addi r10, r0, 3
P 1d285000  # 09 shr r9, r8, r10
P 21600000  # 10 addi r11, r0, 0
P 21800003  # 11 addi r12, r0, 3
P 21a00000  # 12 addi r13, r0, 0
P 21ad0007  # 13 loop: addi r13, r13, 7
P 216b0001  # 14 addi r11, r11, 1
P 240b6000  # 15 cmplt r11, r12
P 2c00000d  # 16 bc 13
P 28000013  # 17 jmp 19
P 21c00055  # 18 addi r14, r0, 0x55 (skipped)
P 05ed5800  # 19 add r15, r13, r11
P 30000000  # 20 halt
P 22000001  # 21 addi r16, r0, 1 (behind halt)
W 01 00000005
W 02 0000000c
W 03 00000011
W 04 0000000c
W 05 00000004
W 06 00000015
W 07 00000019
W 08 00000320
W 0a 00000003
W 09 00000064
W 0b 00000000
W 0c 00000003
W 0d 00000000
W 0d 00000007  # loop pass 1
W 0b 00000001
W 0d 0000000e  # loop pass 2
W 0b 00000002
W 0d 00000015  # loop pass 3
W 0b 00000003
W 0f 00000018
T 20

// ==== tb/tb_scalar_unit.sv ====
// Trace-driven testbench for the scalar unit: program load, random run gaps, write-back order
`default_nettype none

module tb_scalar_unit;

	localparam int PROG_DEPTH      = 256;
	localparam int DATA_W          = 32;
	localparam int CYCLES_PER_LINE = 200;
	localparam int ACK_LIMIT       = 16;
	localparam int POST_TERM       = 20;

	logic               clock;
	logic               reset;
	logic               run;
	logic               store_req;
	isa_pkg::instr_u    store_instr;
	logic               store_ack;
	logic               wb_valid;
	pipe_pkg::reg_idx_t wb_dst;
	logic [DATA_W-1:0]  wb_data;
	logic               term;

	// Trace contents
	logic [31:0]        prog_words [$];
	pipe_pkg::reg_idx_t exp_dst [$];
	logic [DATA_W-1:0]  exp_data [$];
	int                 exp_term = -1;
	int                 trace_lines = 0;
	logic               trace_ok = 1'b0;

	integer seed = 73439;
	int     errors = 0;
	int     checks = 0;
	int     ack_count = 0;
	int     wb_count = 0;
	logic   term_seen = 1'b0;

	scalar_unit #(
		.PROG_DEPTH (PROG_DEPTH),
		.DATA_W     (DATA_W)
	) dut_i (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.store_req   (store_req),
		.store_instr (store_instr),
		.store_ack   (store_ack),
		.wb_valid    (wb_valid),
		.wb_dst      (wb_dst),
		.wb_data     (wb_data),
		.term        (term)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Every ack pulse is counted, also one that comes without a request
	always @(negedge clock) begin
		if (!reset && store_ack) begin
			ack_count++;
		end
	end

	//////////////////////////////
	// Trace parsing
	task automatic read_trace();
		int                 fd;
		int                 n;
		int                 count;
		string              line;
		string              body;
		byte                tag;
		logic [31:0]        word;
		pipe_pkg::reg_idx_t dst;
		logic [DATA_W-1:0]  data;
		fd = $fopen("tb/scalar_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open trace file tb/scalar_trace.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				tag  = line.getc(0);
				body = line.substr(1, line.len() - 1);
				n    = -1;
				if (tag == "P") begin
					n = $sscanf(body, "%h", word);
					prog_words.push_back(word);
					n = (n == 1) ? 0 : 1;
				end else if (tag == "W") begin
					n = $sscanf(body, "%h %h", dst, data);
					exp_dst.push_back(dst);
					exp_data.push_back(data);
					n = (n == 2) ? 0 : 1;
				end else if (tag == "T") begin
					n = $sscanf(body, "%d", count);
					exp_term = count;
					n = (n == 1) ? 0 : 1;
				end
				// Comment and blank lines leave n at -1
				if (n == 0) begin
					trace_lines++;
				end else if (n > 0) begin
					errors++;
					$display("malformed trace line: %s", line);
				end
			end
			$fclose(fd);
			if (prog_words.size() == 0 || exp_dst.size() == 0 || exp_term < 0) begin
				errors++;
				$display("trace file lacks program words, write-backs or the term count");
			end else begin
				trace_ok = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Program load over the store handshake
	task automatic load_program();
		int i;
		int wait_n;
		for (i = 0; i < prog_words.size(); i++) begin
			store_req   = 1'b1;
			store_instr = prog_words[i];
			wait_n      = 0;
			do begin
				@(negedge clock);
				wait_n++;
			end while (!store_ack && wait_n < ACK_LIMIT);
			checks++;
			if (!store_ack) begin
				errors++;
				$display("no store_ack for program word %0d", i);
			end
			store_req = 1'b0;
			@(negedge clock);
			checks++;
			// Ack is a one-cycle pulse
			if (store_ack) begin
				errors++;
				$display("store_ack stayed high after program word %0d", i);
			end
		end
	endtask

	task automatic check_writeback();
		checks++;
		if (term_seen) begin
			errors++;
			$display("write-back to r%0d after term was raised", wb_dst);
		end else if (wb_count >= exp_dst.size()) begin
			errors++;
			$display("extra write-back to r%0d beyond the end of the trace", wb_dst);
		end else if (wb_dst != exp_dst[wb_count] || wb_data != exp_data[wb_count]) begin
			errors++;
			$display("error at %0t: write-back %0d gave r%0d = %h, expected r%0d = %h",
				$time, wb_count, wb_dst, wb_data, exp_dst[wb_count], exp_data[wb_count]);
		end
		wb_count++;
	endtask

	//////////////////////////////
	// Execution with random run gaps
	task automatic run_program();
		int post;
		post = 0;
		while (post < POST_TERM) begin
			@(negedge clock);
			run = ($random(seed) & 3) != 0;
			// Outputs settle well before the next rising edge
			#1;
			if (wb_valid) begin
				check_writeback();
			end
			if (term_seen) begin
				post++;
				checks++;
				if (!term) begin
					errors++;
					$display("term dropped after it was raised");
				end
			end else if (term) begin
				term_seen = 1'b1;
				checks++;
				if (wb_count != exp_term) begin
					errors++;
					$display("error at %0t: term after %0d write-backs, expected %0d",
						$time, wb_count, exp_term);
				end
			end
		end
		checks++;
		if (wb_count != exp_dst.size()) begin
			errors++;
			$display("error at %0t: %0d write-backs seen, expected %0d", $time, wb_count,
				exp_dst.size());
		end
	endtask

	initial begin
		reset       = 1'b1;
		run         = 1'b0;
		store_req   = 1'b0;
		store_instr = '0;
		read_trace();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		if (trace_ok) begin
			load_program();
			run_program();
			checks++;
			if (ack_count != prog_words.size()) begin
				errors++;
				$display("error at %0t: %0d store acks, expected %0d", $time, ack_count,
					prog_words.size());
			end
		end
		$display("summary: %0d checks, %0d errors, %0d write-backs, %0d store acks",
			checks, errors, wb_count, ack_count);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog sized from the trace length
	initial begin
		wait (trace_ok);
		repeat (CYCLES_PER_LINE * trace_lines) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles",
			CYCLES_PER_LINE * trace_lines);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
